/* source/mips_pkg.sv */
package mips_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int xlen        = 32;
	localparam int reg_addr_w  = 5;
	// 64 words each
	localparam int imem_addr_w = 6;
	localparam int dmem_addr_w = 6;

	// R-type function field codes
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// Primary opcodes, MIPS encodings except HALT
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_t;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [xlen-1:0] instr;
		logic [xlen-1:0] pc_plus4;
	} if_id_t;

	typedef struct packed {
		logic [xlen-1:0]       rs_val;
		logic [xlen-1:0]       rt_val;
		logic [xlen-1:0]       imm;
		logic [xlen-1:0]       pc_plus4;
		logic [reg_addr_w-1:0] dest;
		alu_op_t               alu_op;
		logic                  use_imm;
		logic                  mem_read;
		logic                  mem_write;
		logic                  reg_write;
		logic                  branch;
		logic                  halt;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0]       result;
		logic [xlen-1:0]       store_data;
		logic [reg_addr_w-1:0] dest;
		logic                  mem_read;
		logic                  mem_write;
		logic                  reg_write;
		logic                  halt;
	} ex_mem_t;

	typedef struct packed {
		logic [xlen-1:0]       wb_data;
		logic [reg_addr_w-1:0] dest;
		logic                  reg_write;
		logic                  halt;
	} mem_wb_t;

endpackage

/* source/mips_inst_mem.sv */
`timescale 1ns/1ns

module mips_inst_mem (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             load_req,
	input  logic [mips_pkg::imem_addr_w-1:0] load_addr,
	input  logic [mips_pkg::xlen-1:0]        load_data,
	output logic                             load_ack,
	input  logic [mips_pkg::imem_addr_w-1:0] fetch_addr,
	output logic [mips_pkg::xlen-1:0]        fetch_instr
);

	logic [mips_pkg::xlen-1:0] mem [2**mips_pkg::imem_addr_w];

	// Four-phase loader
	// Write only on the req-high / ack-low phase, so one write per request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_ack <= 1'b0;
		end else if (load_req && !load_ack) begin
			load_ack <= 1'b1;
		end else if (!load_req && load_ack) begin
			load_ack <= 1'b0;
		end
	end

	// Word storage, no reset on contents
	always_ff @(posedge clk) begin
		if (load_req && !load_ack) begin
			mem[load_addr] <= load_data;
		end
	end

	// Combinational fetch port
	assign fetch_instr = mem[fetch_addr];

endmodule

/* source/mips_reg_file.sv */
`timescale 1ns/1ns

module mips_reg_file (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
	input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
	input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
	output logic [mips_pkg::xlen-1:0]       rs_data,
	output logic [mips_pkg::xlen-1:0]       rt_data,
	output logic [mips_pkg::xlen-1:0]       dbg_data,
	input  logic                            wr_en,
	input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [mips_pkg::xlen-1:0]       wr_data
);

	logic [mips_pkg::xlen-1:0] regs [2**mips_pkg::reg_addr_w];
	logic                      wr_live;

	// Writes to r0 are dropped
	assign wr_live = wr_en && (wr_addr != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through so decode sees the value being retired
	assign rs_data = (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

	// Debug port shows the stored value, one cycle after writeback
	assign dbg_data = regs[dbg_addr];

endmodule

/* source/mips_decoder.sv */
`timescale 1ns/1ns

module mips_decoder (
	input  logic [mips_pkg::xlen-1:0] instr,
	output mips_pkg::id_ex_t          ctrl
);

	mips_pkg::opcode_t                op;
	logic [5:0]                       funct;
	logic [mips_pkg::reg_addr_w-1:0]  rt;
	logic [mips_pkg::reg_addr_w-1:0]  rd;

	// Instruction fields
	assign op    = mips_pkg::opcode_t'(instr[31:26]);
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign funct = instr[5:0];

	always_comb begin
		// Everything off by default as in a NOP
		ctrl      = '0;
		ctrl.imm  = {{(mips_pkg::xlen-16){instr[15]}}, instr[15:0]};
		ctrl.dest = rt;
		case (op)
			mips_pkg::OP_RTYPE: begin
				ctrl.dest      = rd;
				ctrl.reg_write = 1'b1;
				case (funct)
					mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::ALU_SLT;
					// Unknown funct and the all-zero NOP
					default:           ctrl.reg_write = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			mips_pkg::OP_LW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				// Compare happens in execute
				ctrl.branch = 1'b1;
			end
			mips_pkg::OP_HALT: begin
				ctrl.halt = 1'b1;
			end
			default: begin
				ctrl.dest = '0;
			end
		endcase
	end

endmodule

/* source/mips_execute.sv */
`timescale 1ns/1ns

module mips_execute (
	input  mips_pkg::id_ex_t          stage,
	output logic [mips_pkg::xlen-1:0] result,
	output logic [mips_pkg::xlen-1:0] store_data,
	output logic                      branch_taken,
	output logic [mips_pkg::xlen-1:0] branch_target
);

	logic [mips_pkg::xlen-1:0] op_a;
	logic [mips_pkg::xlen-1:0] op_b;

	// Operand select
	assign op_a = stage.rs_val;
	assign op_b = stage.use_imm ? stage.imm : stage.rt_val;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (stage.alu_op)
			mips_pkg::ALU_ADD: result = op_a + op_b;
			mips_pkg::ALU_SUB: result = op_a - op_b;
			mips_pkg::ALU_AND: result = op_a & op_b;
			mips_pkg::ALU_OR:  result = op_a | op_b;
			// Signed compare
			mips_pkg::ALU_SLT: begin
				result = {{(mips_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			default:           result = '0;
		endcase
	end

	// SW stores rt
	assign store_data = stage.rt_val;

	// Branch target, word offset from PC+4
	assign branch_target = stage.pc_plus4 + {stage.imm[mips_pkg::xlen-3:0], 2'b00};
	assign branch_taken  = stage.branch && (stage.rs_val == stage.rt_val);

endmodule

/* source/mips_data_mem.sv */
`timescale 1ns/1ns

module mips_data_mem (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wr_en,
	input  logic [mips_pkg::xlen-1:0] addr,
	input  logic [mips_pkg::xlen-1:0] wr_data,
	output logic [mips_pkg::xlen-1:0] rd_data
);

	logic [mips_pkg::xlen-1:0]        mem [2**mips_pkg::dmem_addr_w];
	logic [mips_pkg::dmem_addr_w-1:0] word_idx;

	// Byte address to word index, low two bits ignored
	assign word_idx = addr[mips_pkg::dmem_addr_w+1:2];

	// Cleared at reset for known start contents
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**mips_pkg::dmem_addr_w; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[word_idx] <= wr_data;
		end
	end

	assign rd_data = mem[word_idx];

endmodule

/* source/mips_top.sv */
`timescale 1ns/1ns

module mips_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             run,
	input  logic                             load_req,
	input  logic [mips_pkg::imem_addr_w-1:0] load_addr,
	input  logic [mips_pkg::xlen-1:0]        load_data,
	output logic                             load_ack,
	input  logic [mips_pkg::reg_addr_w-1:0]  dbg_reg_addr,
	output logic [mips_pkg::xlen-1:0]        dbg_reg_data,
	output logic [mips_pkg::xlen-1:0]        pc,
	output logic                             halt
);

	// Pipeline registers
	mips_pkg::if_id_t  if_id;
	mips_pkg::id_ex_t  id_ex;
	mips_pkg::ex_mem_t ex_mem;
	mips_pkg::mem_wb_t mem_wb;

	// Next-state for the registers
	mips_pkg::id_ex_t  dec_ctrl;
	mips_pkg::id_ex_t  id_next;
	mips_pkg::ex_mem_t ex_next;
	mips_pkg::mem_wb_t wb_next;

	logic [mips_pkg::xlen-1:0] fetch_instr;
	logic [mips_pkg::xlen-1:0] pc_plus4;
	logic                      fetch_halt;
	logic                      fetch_stop;
	logic [mips_pkg::xlen-1:0] rs_data;
	logic [mips_pkg::xlen-1:0] rt_data;
	logic [mips_pkg::xlen-1:0] ex_result;
	logic [mips_pkg::xlen-1:0] ex_store_data;
	logic                      branch_taken;
	logic [mips_pkg::xlen-1:0] branch_target;
	logic [mips_pkg::xlen-1:0] dmem_rd_data;

	////////////////////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////////////////////

	assign pc_plus4   = pc + 32'd4;
	assign fetch_halt = (fetch_instr[31:26] == mips_pkg::OP_HALT);

	mips_inst_mem u_inst_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_ack    (load_ack),
		.fetch_addr  (pc[mips_pkg::imem_addr_w+1:2]),
		.fetch_instr (fetch_instr)
	);

	// PC hold on HALT beats the branch redirect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!run) begin
			pc <= '0;
		end else if (fetch_stop || fetch_halt) begin
			pc <= pc;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else begin
			pc <= pc_plus4;
		end
	end

	// Once HALT is in, fetch feeds NOPs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_stop <= 1'b0;
		end else if (!run) begin
			fetch_stop <= 1'b0;
		end else if (fetch_halt) begin
			fetch_stop <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '0;
		end else if (!run || fetch_stop) begin
			if_id <= '0;
		end else begin
			if_id.instr    <= fetch_instr;
			if_id.pc_plus4 <= pc_plus4;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	mips_decoder u_decoder (
		.instr (if_id.instr),
		.ctrl  (dec_ctrl)
	);

	mips_reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs_addr  (if_id.instr[25:21]),
		.rt_addr  (if_id.instr[20:16]),
		.dbg_addr (dbg_reg_addr),
		.rs_data  (rs_data),
		.rt_data  (rt_data),
		.dbg_data (dbg_reg_data),
		.wr_en    (mem_wb.reg_write),
		.wr_addr  (mem_wb.dest),
		.wr_data  (mem_wb.wb_data)
	);

	// Decoder leaves operands zero, fill them here
	always_comb begin
		id_next          = dec_ctrl;
		id_next.rs_val   = rs_data;
		id_next.rt_val   = rt_data;
		id_next.pc_plus4 = if_id.pc_plus4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (!run) begin
			id_ex <= '0;
		end else begin
			id_ex <= id_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////

	mips_execute u_execute (
		.stage         (id_ex),
		.result        (ex_result),
		.store_data    (ex_store_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	always_comb begin
		ex_next.result     = ex_result;
		ex_next.store_data = ex_store_data;
		ex_next.dest       = id_ex.dest;
		ex_next.mem_read   = id_ex.mem_read;
		ex_next.mem_write  = id_ex.mem_write;
		ex_next.reg_write  = id_ex.reg_write;
		ex_next.halt       = id_ex.halt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else if (!run) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= ex_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////////////////////////////////////////

	mips_data_mem u_data_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (ex_mem.mem_write),
		.addr    (ex_mem.result),
		.wr_data (ex_mem.store_data),
		.rd_data (dmem_rd_data)
	);

	// Writeback mux, load data or ALU result
	always_comb begin
		wb_next.wb_data   = ex_mem.mem_read ? dmem_rd_data : ex_mem.result;
		wb_next.dest      = ex_mem.dest;
		wb_next.reg_write = ex_mem.reg_write;
		wb_next.halt      = ex_mem.halt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else if (!run) begin
			mem_wb <= '0;
		end else begin
			mem_wb <= wb_next;
		end
	end

	// Sticky halt, set the cycle after HALT writes back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halt <= 1'b0;
		end else if (!run) begin
			halt <= 1'b0;
		end else if (mem_wb.halt) begin
			halt <= 1'b1;
		end
	end

endmodule

/* verif/mips_tb.sv */
`timescale 1ns/1ns

module mips_tb;

	logic                             clk;
	logic                             rst_n;
	logic                             run;
	logic                             load_req;
	logic [mips_pkg::imem_addr_w-1:0] load_addr;
	logic [mips_pkg::xlen-1:0]        load_data;
	logic                             load_ack;
	logic [mips_pkg::reg_addr_w-1:0]  dbg_reg_addr;
	logic [mips_pkg::xlen-1:0]        dbg_reg_data;
	logic [mips_pkg::xlen-1:0]        pc;
	logic                             halt;

	// Program image loaded word by word into the DUT
	logic [31:0] prog [64];
	int          prog_len;

	// Reference model state
	logic [31:0] model_regs [32];
	logic [31:0] model_dmem [64];
	int          model_fetches;
	logic [31:0] model_halt_pc;

	// Bookkeeping
	int seed;
	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	int handshakes;

	mips_top u_mips_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.load_req     (load_req),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.load_ack     (load_ack),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.pc           (pc),
		.halt         (halt)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ack pulses seen on the loader port
	always @(posedge load_ack) begin
		handshakes++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Low-level helpers
	////////////////////////////////////////////////////////////////////////////

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %-12s ok", name);
		end else begin
			tests_failed++;
			$display("test %-12s failed with %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	// 10 cycles of reset with all inputs idle
	task automatic apply_reset();
		rst_n        = 1'b0;
		run          = 1'b0;
		load_req     = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		dbg_reg_addr = '0;
		repeat (10) step();
		rst_n = 1'b1;
		step();
	endtask

	// Debug port is combinational so sample 1 ns after driving
	task automatic read_reg(input logic [4:0] idx, output logic [31:0] val);
		step();
		dbg_reg_addr = idx;
		#1;
		val = dbg_reg_data;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_type(input logic [5:0] funct, input int rd,
		input int rs, input int rt);
		return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	// Field order is op rs rt imm but args come as rt then rs
	function automatic logic [31:0] i_type(input logic [5:0] op, input int rt,
		input int rs, input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] halt_word();
		return {mips_pkg::OP_HALT, 26'd0};
	endfunction

	task automatic clear_program();
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
		end
		prog_len = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// In-order ISA model with two delay slots after a taken BEQ
	task automatic model_program();
		logic [31:0] mpc;
		logic [31:0] next;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] ea;
		logic [31:0] v;
		logic [31:0] target;
		logic [4:0]  wd;
		logic        wr;
		logic        done;
		int          slots;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		// Data memory clears at reset
		for (int i = 0; i < 64; i++) begin
			model_dmem[i] = '0;
		end
		mpc           = '0;
		target        = '0;
		slots         = 0;
		steps         = 0;
		done          = 1'b0;
		model_fetches = 0;
		while (!done && steps < 500) begin
			steps++;
			ins = prog[mpc[7:2]];
			a   = model_regs[ins[25:21]];
			b   = model_regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ea  = a + imm;
			if (ins[31:26] == mips_pkg::OP_HALT) begin
				done          = 1'b1;
				model_halt_pc = mpc;
			end else begin
				model_fetches++;
				next = mpc + 32'd4;
				// Redirect once the last delay slot is done
				if (slots > 0) begin
					slots--;
					if (slots == 0) begin
						next = target;
					end
				end
				wr = 1'b0;
				wd = ins[20:16];
				v  = '0;
				case (ins[31:26])
					mips_pkg::OP_RTYPE: begin
						wd = ins[15:11];
						wr = 1'b1;
						case (ins[5:0])
							mips_pkg::fn_addu: v = a + b;
							mips_pkg::fn_subu: v = a - b;
							mips_pkg::fn_and:  v = a & b;
							mips_pkg::fn_or:   v = a | b;
							mips_pkg::fn_slt:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
							// NOP and unknown funct
							default:           wr = 1'b0;
						endcase
					end
					mips_pkg::OP_ADDI: begin
						v  = ea;
						wr = 1'b1;
					end
					mips_pkg::OP_LW: begin
						v  = model_dmem[ea[7:2]];
						wr = 1'b1;
					end
					mips_pkg::OP_SW: begin
						model_dmem[ea[7:2]] = b;
					end
					mips_pkg::OP_BEQ: begin
						if (a == b) begin
							slots  = 2;
							target = mpc + 32'd4 + {imm[29:0], 2'b00};
						end
					end
					default: begin
					end
				endcase
				// r0 stays zero
				if (wr && wd != 5'd0) begin
					model_regs[wd] = v;
				end
				mpc = next;
			end
		end
		if (!done) begin
			$display("Reference model ran 500 steps without reaching HALT");
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Loader and run control
	////////////////////////////////////////////////////////////////////////////

	// Four-phase handshake with ack one cycle after each req edge
	task automatic load_word(input logic [5:0] addr, input logic [31:0] data);
		int cnt;
		check_value("load_ack idle before request", {31'd0, load_ack}, 32'd0);
		load_addr = addr;
		load_data = data;
		load_req  = 1'b1;
		cnt       = 0;
		while (!load_ack) begin
			if (cnt >= 20) abort_on_timeout("load_ack to rise");
			step();
			cnt++;
		end
		check_value("load_ack rise latency", cnt, 32'd1);
		load_req = 1'b0;
		cnt      = 0;
		while (load_ack) begin
			if (cnt >= 20) abort_on_timeout("load_ack to fall");
			step();
			cnt++;
		end
		check_value("load_ack fall latency", cnt, 32'd1);
	endtask

	task automatic compare_regs();
		logic [31:0] val;
		for (int i = 0; i < 32; i++) begin
			read_reg(i[4:0], val);
			check_value($sformatf("register r%0d", i), val, model_regs[i]);
		end
	endtask

	// Load and run one program to HALT and compare every register
	task automatic run_program();
		int          cnt;
		logic [31:0] held_pc;
		apply_reset();
		for (int i = 0; i < prog_len; i++) begin
			load_word(i[5:0], prog[i]);
		end
		model_program();
		run = 1'b1;
		cnt = 0;
		while (!halt) begin
			if (cnt >= 1000) abort_on_timeout("halt to rise");
			step();
			cnt++;
		end
		// HALT is fetched after model_fetches words and halt rises 5 cycles later
		check_value("cycles until halt", cnt, model_fetches + 5);
		check_value("pc at halt", pc, model_halt_pc);
		held_pc = pc;
		repeat (3) step();
		check_value("pc holds after halt", pc, held_pc);
		check_value("halt stays high", {31'd0, halt}, 32'd1);
		compare_regs();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		logic [31:0] val;
		apply_reset();
		check_value("pc after reset", pc, 32'd0);
		check_value("halt after reset", {31'd0, halt}, 32'd0);
		check_value("load_ack after reset", {31'd0, load_ack}, 32'd0);
		for (int i = 0; i < 32; i++) begin
			read_reg(i[4:0], val);
			check_value($sformatf("r%0d after reset", i), val, 32'd0);
		end
		finish_test("reset_state");
	endtask

	task automatic test_loader();
		logic [31:0] val;
		clear_program();
		handshakes = 0;
		emit(i_type(mips_pkg::OP_ADDI, 1, 0, 42));
		emit(i_type(mips_pkg::OP_ADDI, 2, 0, 3));
		emit(32'd0);
		emit(32'd0);
		emit(r_type(mips_pkg::fn_addu, 3, 1, 2));
		emit(halt_word());
		run_program();
		check_value("loader handshakes", handshakes, prog_len);
		read_reg(5'd3, val);
		check_value("r3 of loaded program", val, 32'd45);
		finish_test("loader");
	endtask

	task automatic test_arith();
		logic [31:0] val;
		clear_program();
		emit(i_type(mips_pkg::OP_ADDI, 1, 0, 100));
		emit(i_type(mips_pkg::OP_ADDI, 2, 0, -7));
		emit(i_type(mips_pkg::OP_ADDI, 3, 0, 'h0f0f));
		emit(i_type(mips_pkg::OP_ADDI, 4, 0, 'h00ff));
		emit(r_type(mips_pkg::fn_addu, 5, 1, 2));
		emit(r_type(mips_pkg::fn_subu, 6, 1, 2));
		emit(r_type(mips_pkg::fn_and, 7, 3, 4));
		emit(r_type(mips_pkg::fn_or, 8, 3, 4));
		emit(r_type(mips_pkg::fn_slt, 9, 2, 1));
		emit(r_type(mips_pkg::fn_slt, 10, 1, 2));
		// Writes aimed at r0
		emit(i_type(mips_pkg::OP_ADDI, 0, 0, 55));
		emit(r_type(mips_pkg::fn_addu, 0, 1, 1));
		emit(32'd0);
		emit(r_type(mips_pkg::fn_addu, 11, 0, 1));
		emit(halt_word());
		run_program();
		read_reg(5'd0, val);
		check_value("r0 after writes", val, 32'd0);
		finish_test("arith");
	endtask

	task automatic test_memory();
		logic [31:0] val;
		clear_program();
		emit(i_type(mips_pkg::OP_ADDI, 1, 0, 'h11));
		emit(i_type(mips_pkg::OP_ADDI, 2, 0, -5));
		emit(i_type(mips_pkg::OP_ADDI, 3, 0, 'h1234));
		emit(i_type(mips_pkg::OP_ADDI, 4, 0, 8));
		emit(i_type(mips_pkg::OP_SW, 1, 0, 0));
		emit(i_type(mips_pkg::OP_SW, 3, 0, 60));
		emit(i_type(mips_pkg::OP_SW, 2, 4, 4));
		emit(i_type(mips_pkg::OP_LW, 5, 0, 0));
		emit(i_type(mips_pkg::OP_LW, 6, 4, 4));
		emit(i_type(mips_pkg::OP_LW, 7, 0, 60));
		// Same word as 4(r4) by absolute address
		emit(i_type(mips_pkg::OP_LW, 8, 0, 12));
		emit(r_type(mips_pkg::fn_addu, 9, 5, 6));
		emit(i_type(mips_pkg::OP_LW, 10, 0, 16));
		emit(halt_word());
		run_program();
		read_reg(5'd8, val);
		check_value("r8 loaded from address 12", val, 32'hffff_fffb);
		finish_test("memory");
	endtask

	task automatic test_branch();
		logic [31:0] val;
		clear_program();
		emit(i_type(mips_pkg::OP_ADDI, 1, 0, 7));
		emit(i_type(mips_pkg::OP_ADDI, 2, 0, 7));
		emit(i_type(mips_pkg::OP_ADDI, 3, 0, 9));
		emit(32'd0);
		// Word 4 is taken to word 10
		emit(i_type(mips_pkg::OP_BEQ, 2, 1, 5));
		emit(i_type(mips_pkg::OP_ADDI, 10, 0, 1));
		emit(i_type(mips_pkg::OP_ADDI, 11, 0, 1));
		emit(i_type(mips_pkg::OP_ADDI, 12, 0, 1));
		emit(i_type(mips_pkg::OP_ADDI, 13, 0, 1));
		emit(i_type(mips_pkg::OP_ADDI, 14, 0, 1));
		// Word 10 is not taken
		emit(i_type(mips_pkg::OP_BEQ, 3, 1, 3));
		emit(i_type(mips_pkg::OP_ADDI, 15, 0, 1));
		emit(i_type(mips_pkg::OP_ADDI, 16, 0, 1));
		emit(i_type(mips_pkg::OP_ADDI, 17, 0, 1));
		emit(halt_word());
		run_program();
		read_reg(5'd11, val);
		check_value("second delay slot marker", val, 32'd1);
		read_reg(5'd12, val);
		check_value("skipped marker", val, 32'd0);
		read_reg(5'd17, val);
		check_value("fall-through marker", val, 32'd1);
		finish_test("branch");
	endtask

	task automatic pick_source(input int avoid_a, input int avoid_b, output int src);
		logic [31:0] rnd;
		rnd = $random(seed);
		while (int'(rnd[4:0]) == avoid_a || int'(rnd[4:0]) == avoid_b) begin
			rnd = $random(seed);
		end
		src = int'(rnd[4:0]);
	endtask

	// Sources never come from the last two destinations
	task automatic test_random();
		logic [31:0] rnd;
		int          dest;
		int          src_a;
		int          src_b;
		int          recent_0;
		int          recent_1;
		for (int p = 0; p < 4; p++) begin
			clear_program();
			recent_0 = -1;
			recent_1 = -1;
			for (int n = 0; n < 30; n++) begin
				rnd  = $random(seed);
				dest = int'(rnd[4:0]);
				pick_source(recent_0, recent_1, src_a);
				pick_source(recent_0, recent_1, src_b);
				case (rnd[6:5])
					2'd2: emit(r_type(mips_pkg::fn_addu, dest, src_a, src_b));
					2'd3: emit(r_type(mips_pkg::fn_subu, dest, src_a, src_b));
					default: emit(i_type(mips_pkg::OP_ADDI, dest, src_a, int'(rnd[31:16])));
				endcase
				recent_1 = recent_0;
				recent_0 = dest;
			end
			emit(halt_word());
			run_program();
		end
		finish_test("random");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed              = 10701;
		errors            = 0;
		tests_run         = 0;
		tests_failed      = 0;
		test_start_errors = 0;
		handshakes        = 0;
		prog_len          = 0;
		rst_n             = 1'b0;
		run               = 1'b0;
		load_req          = 1'b0;
		load_addr         = '0;
		load_data         = '0;
		dbg_reg_addr      = '0;
		test_reset_state();
		test_loader();
		test_arith();
		test_memory();
		test_branch();
		test_random();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* verilog.f */
source/mips_pkg.sv
source/mips_inst_mem.sv
source/mips_reg_file.sv
source/mips_decoder.sv
source/mips_execute.sv
source/mips_data_mem.sv
source/mips_top.sv
verif/mips_tb.sv

/* Makefile */
# Verilator build and run for the MIPS pipeline testbench

VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
